/* Makefile */
VERILATOR  ?= verilator
TOP        := apu_tb
FILELIST   := compile.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
rtl/apu_pkg.sv
rtl/mem_map_registers.sv
rtl/frame_counter.sv
rtl/length_counter.sv
rtl/triangle_channel.sv
rtl/apu.sv
testbench/tb_clock.sv
testbench/apu_tb.sv

/* rtl/apu.sv */
`timescale 1ns/1ps

module apu
  import apu_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       cpu_clk_en,
  input  reg_req_t   req,
  output logic [7:0] rdata,
  output logic       irq,
  output logic [3:0] triangle_wave
);

  reg_array_t     reg_array;
  logic [23:0]    reg_updates;
  triangle_t      triangle_signals;
  status_t        status_signals;
  frame_counter_t fc_signals;
  logic           frame_interrupt;
  logic           clear_interrupt;
  logic           quarter_clk_en;
  logic           half_clk_en;
  logic           tri_length_non_zero;
  logic [4:0]     lengths_non_zero;

  // ----------------------------------------------------------------------
  // register field unpacking
  // ----------------------------------------------------------------------
  assign triangle_signals.linear_load_data = reg_array[tri_linear_addr][6:0];
  assign triangle_signals.length_halt      = reg_array[tri_linear_addr][7];
  assign triangle_signals.timer_load_data  = {reg_array[tri_timer_hi_addr][2:0],
                                              reg_array[tri_timer_lo_addr]};
  assign triangle_signals.length_load_data = reg_array[tri_timer_hi_addr][7:3];
  assign status_signals   = reg_array[status_addr][4:0];
  assign fc_signals       = reg_array[frame_addr][7:6];
  assign lengths_non_zero = {2'b00, tri_length_non_zero, 2'b00};  // only triangle
  assign irq              = frame_interrupt;

  mem_map_registers mm_reg (
    .clk, .arst_n, .cpu_clk_en, .req,
    .frame_interrupt,
    .length_non_zero (lengths_non_zero),
    .reg_array, .reg_updates, .rdata, .clear_interrupt
  );

  frame_counter fc (
    .clk, .arst_n, .cpu_clk_en,
    .mode              (fc_signals.mode),
    .load              (reg_updates[frame_addr]),
    .inhibit_interrupt (fc_signals.inhibit_interrupt),
    .clear_interrupt,
    .interrupt         (frame_interrupt),
    .quarter_clk_en, .half_clk_en
  );

  triangle_channel tc (
    .clk, .arst_n, .cpu_clk_en, .quarter_clk_en, .half_clk_en,
    .disable_l        (status_signals.triangle_en),
    .length_halt      (triangle_signals.length_halt),
    .linear_load      (reg_updates[tri_linear_addr] | reg_updates[tri_timer_hi_addr]),
    .length_load      (reg_updates[tri_timer_hi_addr]),
    .linear_load_data (triangle_signals.linear_load_data),
    .timer_load_data  (triangle_signals.timer_load_data),
    .length_load_data (triangle_signals.length_load_data),
    .length_non_zero  (tri_length_non_zero),
    .wave             (triangle_wave)
  );

endmodule : apu

/* rtl/apu_pkg.sv */
package apu_pkg;

  localparam int unsigned num_regs = 24;

  // ----------------------------------------------------------------------
  // bus and register field types
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic       en;
    logic       we;
    logic [4:0] addr;
    logic [7:0] data;
  } reg_req_t;

  typedef struct packed {
    logic [6:0]  linear_load_data;
    logic        length_halt;       // also the linear control flag
    logic [10:0] timer_load_data;
    logic [4:0]  length_load_data;
  } triangle_t;

  typedef struct packed {
    logic dmc_en;
    logic noise_en;
    logic triangle_en;
    logic pulse2_en;
    logic pulse1_en;
  } status_t;

  typedef struct packed {
    logic mode;                     // 1 = five-step
    logic inhibit_interrupt;
  } frame_counter_t;

  typedef logic [num_regs-1:0][7:0] reg_array_t;

  localparam logic [4:0] tri_linear_addr   = 5'd8;
  localparam logic [4:0] tri_timer_lo_addr = 5'd10;
  localparam logic [4:0] tri_timer_hi_addr = 5'd11;
  localparam logic [4:0] status_addr       = 5'd21;
  localparam logic [4:0] frame_addr        = 5'd23;

  // frame sequencer step points, in cpu cycles
  localparam logic [15:0] step1 = 16'd7457;
  localparam logic [15:0] step2 = 16'd14913;
  localparam logic [15:0] step3 = 16'd22371;
  localparam logic [15:0] step4 = 16'd29829;
  localparam logic [15:0] step5 = 16'd37281;

  localparam logic [7:0] length_table [32] = '{
    8'd10,  8'd254, 8'd20,  8'd2,   8'd40,  8'd4,   8'd80,  8'd6,
    8'd160, 8'd8,   8'd60,  8'd10,  8'd14,  8'd12,  8'd26,  8'd14,
    8'd12,  8'd16,  8'd24,  8'd18,  8'd48,  8'd20,  8'd96,  8'd22,
    8'd192, 8'd24,  8'd72,  8'd26,  8'd16,  8'd28,  8'd32,  8'd30
  };

  function automatic logic [7:0] length_lookup(input logic [4:0] index);
    return length_table[index];
  endfunction

endpackage : apu_pkg

/* rtl/frame_counter.sv */
`timescale 1ns/1ps

module frame_counter
  import apu_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  input  logic cpu_clk_en,
  input  logic mode,
  input  logic load,
  input  logic inhibit_interrupt,
  input  logic clear_interrupt,
  output logic interrupt,
  output logic quarter_clk_en,
  output logic half_clk_en
);

  logic [15:0] count;
  logic        quarter_hit;
  logic        half_hit;
  logic        last_step;
  logic        set_irq;

  // ----------------------------------------------------------------------
  // step decode
  // ----------------------------------------------------------------------
  always_comb begin
    quarter_hit = (count == step1) || (count == step2) ||
                  (count == step3) || (count == step4);
    half_hit    = (count == step2);
    if (mode) begin
      quarter_hit = quarter_hit || (count == step5);
      half_hit    = half_hit || (count == step5);
      last_step   = (count == step5);
    end else begin
      half_hit    = half_hit || (count == step4);
      last_step   = (count == step4);
    end
  end

  assign set_irq = !mode && (count == step4);

  // pulses are held until the next enabled cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count          <= '0;
      quarter_clk_en <= 1'b0;
      half_clk_en    <= 1'b0;
    end else if (load) begin
      count          <= '0;
      quarter_clk_en <= mode;  // five-step write clocks at once
      half_clk_en    <= mode;
    end else if (cpu_clk_en) begin
      count          <= last_step ? 16'd0 : count + 16'd1;
      quarter_clk_en <= quarter_hit;
      half_clk_en    <= half_hit;
    end
  end

  // ----------------------------------------------------------------------
  // sticky frame interrupt
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      interrupt <= 1'b0;
    end else if (inhibit_interrupt || clear_interrupt) begin
      interrupt <= 1'b0;
    end else if (cpu_clk_en && set_irq) begin
      interrupt <= 1'b1;
    end
  end

endmodule : frame_counter

/* rtl/length_counter.sv */
`timescale 1ns/1ps

module length_counter
  import apu_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       cpu_clk_en,
  input  logic       half_clk_en,
  input  logic       enable,
  input  logic       halt,
  input  logic       load,
  input  logic [4:0] load_data,
  output logic       non_zero
);

  logic [7:0] count;
  logic       dec;

  assign dec = cpu_clk_en && half_clk_en && !halt && (count != 8'd0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (!enable) begin
      count <= '0;                      // channel off
    end else if (load) begin
      count <= length_lookup(load_data);
    end else if (dec) begin
      count <= count - 8'd1;
    end
  end

  // disable shows up in status right away
  assign non_zero = enable && (count != 8'd0);

endmodule : length_counter

/* rtl/mem_map_registers.sv */
`timescale 1ns/1ps

module mem_map_registers
  import apu_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        cpu_clk_en,
  input  reg_req_t    req,
  input  logic        frame_interrupt,
  input  logic [4:0]  length_non_zero,
  output reg_array_t  reg_array,
  output logic [23:0] reg_updates,
  output logic [7:0]  rdata,
  output logic        clear_interrupt
);

  logic wr_hit;
  logic rd_hit;

  assign wr_hit = req.en && req.we && cpu_clk_en && (req.addr < num_regs);
  assign rd_hit = req.en && !req.we && cpu_clk_en && (req.addr == status_addr);

  assign clear_interrupt = rd_hit;  // flag drops on the read edge

  // ----------------------------------------------------------------------
  // register writes
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_array   <= '0;
      reg_updates <= '0;
    end else begin
      reg_updates <= '0;
      if (wr_hit) begin
        reg_array[req.addr]   <= req.data;
        reg_updates[req.addr] <= 1'b1;  // high the clk after the write
      end
    end
  end

  // status read, old interrupt value captured
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdata <= '0;
    end else if (rd_hit) begin
      rdata <= {1'b0, frame_interrupt, 1'b0, length_non_zero};
    end
  end

endmodule : mem_map_registers

/* rtl/triangle_channel.sv */
`timescale 1ns/1ps

module triangle_channel (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        cpu_clk_en,
  input  logic        quarter_clk_en,
  input  logic        half_clk_en,
  input  logic        disable_l,
  input  logic        length_halt,
  input  logic        linear_load,
  input  logic        length_load,
  input  logic [6:0]  linear_load_data,
  input  logic [10:0] timer_load_data,
  input  logic [4:0]  length_load_data,
  output logic        length_non_zero,
  output logic [3:0]  wave
);

  logic [10:0] timer;
  logic [6:0]  linear;
  logic        linear_reload;
  logic [4:0]  step;
  logic        timer_zero;
  logic        quarter;

  assign timer_zero = (timer == 11'd0);
  assign quarter    = cpu_clk_en && quarter_clk_en;

  length_counter lc (
    .clk,
    .arst_n,
    .cpu_clk_en,
    .half_clk_en,
    .enable    (disable_l),
    .halt      (length_halt),
    .load      (length_load),
    .load_data (length_load_data),
    .non_zero  (length_non_zero)
  );

  // ----------------------------------------------------------------------
  // timer and sequencer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      timer <= '0;
      step  <= '0;
    end else if (cpu_clk_en) begin
      timer <= timer_zero ? timer_load_data : timer - 11'd1;
      if (timer_zero && (linear != 7'd0) && length_non_zero) begin
        step <= step + 5'd1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // linear counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      linear        <= '0;
      linear_reload <= 1'b0;
    end else begin
      if (quarter) begin
        if (linear_reload) begin
          linear <= linear_load_data;
        end else if (linear != 7'd0) begin
          linear <= linear - 7'd1;
        end
        if (!length_halt) begin
          linear_reload <= 1'b0;
        end
      end
      if (linear_load) begin
        linear_reload <= 1'b1;  // register write wins
      end
    end
  end

  assign wave = step[4] ? step[3:0] : ~step[3:0];  // 15..0 then 0..15

endmodule : triangle_channel

/* testbench/apu_tb.sv */
`timescale 1ns/1ps

module apu_tb
  import apu_pkg::*;
();

  typedef struct packed {
    logic [10:0] period;
    logic [6:0]  linear;
    logic [4:0]  len_idx;
    logic        control;
    logic        mode;
    int          window;       // free-running cycles after setup
    int          hold;         // cycles the wave must then stay frozen
    int          min_changes;
    logic [7:0]  status;
    logic        irq;
  } row_t;

  localparam int num_rows = 5;
  localparam int s1 = int'(step1);
  localparam int s2 = int'(step2);
  localparam row_t rows [num_rows] = '{
    '{11'd3,   7'd127, 5'd1, 1'b1, 1'b0, s1 + 160,  0,    32, 8'h04, 1'b0},
    '{11'd20,  7'd127, 5'd1, 1'b1, 1'b1, s1 + 756,  0,    32, 8'h04, 1'b0},
    '{11'd100, 7'd127, 5'd1, 1'b1, 1'b0, s1 + 3434, 0,    32, 8'h04, 1'b0},
    '{11'd10,  7'd1,   5'd1, 1'b0, 1'b0, s2 + 30,   2000, 1,  8'h04, 1'b0},  // freezes at step2
    '{11'd7,   7'd127, 5'd1, 1'b1, 1'b0, s1 + 320,  0,    32, 8'h04, 1'b0}
  };

  logic       clk;
  logic       arst_n;
  logic       cpu_clk_en;
  reg_req_t   req;
  logic [7:0] rdata;
  logic       irq;
  logic [3:0] triangle_wave;

  int   errors = 0;
  int   tests = 0;
  int   failed_tests = 0;
  int   seq_step = 0;      // model of the sequencer position
  int   changes = 0;
  int   gap = -1;
  int   period_now = 0;
  logic gap_check = 1'b0;

  tb_clock clock_gen (.clk, .arst_n);

  apu i_dut (.clk, .arst_n, .cpu_clk_en, .req, .rdata, .irq, .triangle_wave);

  function automatic logic [3:0] seq_wave(input int s);
    if (s < 16) return 4'(15 - s);  // descending half
    return 4'(s - 16);
  endfunction

  function automatic int run_limit();
    int total;
    total = 20000 + s1 + 2 * int'(step4) + int'(step5);
    for (int i = 0; i < num_rows; i++) total += rows[i].window + rows[i].hold;
    return total;
  endfunction

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------
  task automatic check_wave(input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      $display("Fail t=%0t triangle_wave got %h expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_status(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("Fail t=%0t rdata got %h expected %h", $time, got, exp);
      errors++;
    end
  endtask

  task automatic check_irq(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail t=%0t irq got %b expected %b", $time, got, exp);
      errors++;
    end
  endtask

  // every wave change must be the next sequence value
  always @(negedge clk) begin
    int span;
    if (arst_n === 1'b1) begin
      if (gap >= 0) gap = gap + 1;
      if (triangle_wave !== seq_wave(seq_step)) begin
        span = 1;
        seq_step = (seq_step + 1) % 32;
        if (seq_wave(seq_step) === seq_wave((seq_step + 31) % 32)) begin
          seq_step = (seq_step + 1) % 32;  // 0 and 15 repeat at the turns
          span = 2;
        end
        check_wave(triangle_wave, seq_wave(seq_step));
        if (gap_check && gap >= 0 && gap != span * (period_now + 1)) begin
          $display("Fail t=%0t wave step interval got %0d expected %0d",
                   $time, gap, span * (period_now + 1));
          errors++;
        end
        gap = 0;
        changes = changes + span;
      end
    end
  end

  // ----------------------------------------------------------------------
  // bus tasks
  // ----------------------------------------------------------------------
  task automatic write_reg(input logic [4:0] addr, input logic [7:0] data);
    @(posedge clk);
    req <= '{en: 1'b1, we: 1'b1, addr: addr, data: data};
    @(posedge clk);
    req <= '0;
  endtask

  task automatic read_status(output logic [7:0] value);
    @(posedge clk);
    req <= '{en: 1'b1, we: 1'b0, addr: status_addr, data: 8'h00};
    @(posedge clk);
    req <= '0;
    @(negedge clk);
    value = rdata;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic wait_irq(input int limit);
    int n;
    n = 0;
    while (irq !== 1'b1 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (irq !== 1'b1) begin
      $display("frame interrupt did not rise within %0d cycles", limit);
      errors++;
    end
  endtask

  task automatic watch_irq_low(input int cycles);
    logic seen;
    seen = 1'b0;
    repeat (cycles) begin
      @(negedge clk);
      if (irq !== 1'b0) seen = 1'b1;
    end
    if (seen) begin
      $display("frame interrupt rose while it should have stayed low");
      errors++;
    end
  endtask

  task automatic run_row(input row_t r);
    logic [7:0] value;
    gap_check = 1'b0;
    write_reg(frame_addr, {r.mode, 7'd0});  // restart frame sequence first
    write_reg(status_addr, 8'h04);
    write_reg(tri_linear_addr, {r.control, r.linear});
    write_reg(tri_timer_lo_addr, r.period[7:0]);
    write_reg(tri_timer_hi_addr, {r.len_idx, r.period[10:8]});
    gap = -1;
    changes = 0;
    period_now = int'(r.period);
    gap_check = 1'b1;
    wait_cycles(r.window);
    if (changes < r.min_changes) begin
      $display("only %0d wave steps seen, at least %0d expected", changes, r.min_changes);
      errors++;
    end
    if (r.hold > 0) begin
      changes = 0;
      wait_cycles(r.hold);
      if (changes != 0) begin
        $display("wave kept changing after the linear counter ran out");
        errors++;
      end
    end
    @(negedge clk);
    check_irq(irq, r.irq);
    read_status(value);
    check_status(value, r.status);
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %s: pass", name);
    end else begin
      failed_tests++;
      $display("test %s: fail", name);
    end
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    int         errs;
    logic [7:0] value;
    req = '0;
    cpu_clk_en = 1'b1;
    wait (arst_n === 1'b1);
    @(negedge clk);
    errs = errors;
    check_wave(triangle_wave, 4'hf);
    check_irq(irq, 1'b0);
    read_status(value);
    check_status(value, 8'h00);
    end_test("reset", errs);

    for (int i = 0; i < num_rows; i++) begin
      errs = errors;
      run_row(rows[i]);
      end_test($sformatf("row %0d", i), errs);
    end

    errs = errors;
    gap_check = 1'b0;
    write_reg(frame_addr, 8'h00);
    write_reg(status_addr, 8'h04);
    write_reg(tri_linear_addr, 8'h00);
    write_reg(tri_timer_hi_addr, {5'd3, 3'd0});  // length count 2
    wait_cycles(s1);
    read_status(value);
    check_status(value, 8'h04);
    check_irq(irq, 1'b0);
    wait_irq(int'(step4));
    wait_cycles(4);
    read_status(value);
    check_status(value, 8'h40);  // length gone, irq set
    check_irq(irq, 1'b0);
    end_test("length expiry and frame irq", errs);

    errs = errors;
    write_reg(tri_timer_hi_addr, {5'd1, 3'd0});
    read_status(value);
    check_status(value, 8'h04);
    write_reg(status_addr, 8'h00);
    read_status(value);
    check_status(value, 8'h00);
    end_test("status disable", errs);

    errs = errors;
    write_reg(frame_addr, 8'h40);
    watch_irq_low(int'(step4) + 100);
    read_status(value);
    check_status(value, 8'h00);
    end_test("irq inhibit", errs);

    errs = errors;
    write_reg(frame_addr, 8'h80);
    watch_irq_low(int'(step5) + 100);
    read_status(value);
    check_status(value, 8'h00);
    end_test("five-step mode", errs);

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    int limit;
    int cycles;
    limit = run_limit();
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run still going after %0d cycles", limit);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule : apu_tb

/* testbench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule : tb_clock
